// File: src/priv_types_pkg.sv
// ---------------------------------------------------------------------------
// Shared types and constants of the machine-mode privilege unit.
// Imported by the CSR file, the trap arbiter, the trap controller and the top.
// ---------------------------------------------------------------------------
package priv_types_pkg;

  typedef logic [31:0] word_t;

  // Pipeline CSR operation
  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_SWAP = 2'd1,
    CSR_SET  = 2'd2,
    CSR_CLR  = 2'd3
  } csr_op_e;

  // Implemented CSR addresses, timer block is implementation-defined
  typedef enum logic [11:0] {
    MVENDORID = 12'hF11,
    MARCHID   = 12'hF12,
    MIMPID    = 12'hF13,
    MHARTID   = 12'hF14,
    MSTATUS   = 12'h300,
    MISA      = 12'h301,
    MIE       = 12'h304,
    MTVEC     = 12'h305,
    MSCRATCH  = 12'h340,
    MEPC      = 12'h341,
    MCAUSE    = 12'h342,
    MTVAL     = 12'h343,
    MIP       = 12'h344,
    MTIMECMP  = 12'h7C0,
    MTIME     = 12'h7C1,
    MTIMEH    = 12'h7C2,
    MCYCLE    = 12'hB00,
    MINSTRET  = 12'hB02,
    MCYCLEH   = 12'hB80,
    MINSTRETH = 12'hB82
  } csr_addr_e;

  // Synchronous exception codes
  typedef enum logic [30:0] {
    EXC_FETCH_MISALIGNED = 31'd0,
    EXC_ILLEGAL_INSN     = 31'd2,
    EXC_BREAKPOINT       = 31'd3,
    EXC_LOAD_MISALIGNED  = 31'd4,
    EXC_STORE_MISALIGNED = 31'd6,
    EXC_ECALL_M          = 31'd11
  } exc_cause_e;

  // Machine interrupt codes
  typedef enum logic [30:0] {
    INT_SOFTWARE = 31'd3,
    INT_TIMER    = 31'd7,
    INT_EXTERNAL = 31'd11
  } int_cause_e;

  // MXL = 1 (RV32) with only the I extension
  localparam word_t MISA_VALUE = 32'h4000_0100;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // Same positions in mie and mip
  localparam int MIP_MSIP_BIT = 3;
  localparam int MIP_MTIP_BIT = 7;
  localparam int MIP_MEIP_BIT = 11;

endpackage

// File: src/csr_rfile.sv
// ---------------------------------------------------------------------------
// Machine CSR storage with counters, timer compare and pipeline swap/set/clear.
// Hardware trap updates from trap_control override pipeline writes.
// ---------------------------------------------------------------------------
module csr_rfile #(
  parameter priv_types_pkg::word_t HART_ID = '0
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  priv_types_pkg::csr_op_e csr_op,
  input  logic [11:0]             csr_addr,
  input  priv_types_pkg::word_t   csr_wdata,
  input  logic                    instr_retired,
  input  logic                    ext_int,
  input  logic                    soft_int,
  input  logic                    suppress_write,
  input  logic                    mstatus_rup,
  input  logic [1:0]              mstatus_next,
  input  logic                    mepc_rup,
  input  priv_types_pkg::word_t   mepc_next,
  input  logic                    mcause_rup,
  input  priv_types_pkg::word_t   mcause_next,
  input  logic                    mtval_rup,
  input  priv_types_pkg::word_t   mtval_next,
  output priv_types_pkg::word_t   csr_rdata,
  output logic                    invalid_csr,
  output logic                    mstatus_mie,
  output logic                    mstatus_mpie,
  output logic [2:0]              mie_bits,
  output logic [2:0]              mip_bits,
  output priv_types_pkg::word_t   mtvec,
  output priv_types_pkg::word_t   mepc
);
  import priv_types_pkg::*;

  word_t       mscratch;
  word_t       mcause;
  word_t       mtval;
  word_t       mtimecmp;
  logic [63:0] mtime;
  logic [63:0] mtime_nxt;
  logic [63:0] mcycle;
  logic [63:0] minstret;
  word_t       mstatus_word;
  word_t       mie_word;
  word_t       mip_word;
  word_t       wr_data;
  logic        valid_addr;
  logic        wr_en;
  logic        timer_cond;

  // 3-bit vectors are ordered {external, timer, software}
  function automatic word_t expand_irq(logic [2:0] bits);
    word_t w;
    w = '0;
    w[MIP_MSIP_BIT] = bits[0];
    w[MIP_MTIP_BIT] = bits[1];
    w[MIP_MEIP_BIT] = bits[2];
    return w;
  endfunction

  always_comb begin
    mstatus_word = '0;
    mstatus_word[MSTATUS_MIE_BIT]  = mstatus_mie;
    mstatus_word[MSTATUS_MPIE_BIT] = mstatus_mpie;
  end

  assign mie_word = expand_irq(mie_bits);
  assign mip_word = expand_irq(mip_bits);

  // Compare of zero disables the timer
  assign timer_cond = (mtime >= {32'b0, mtimecmp}) && (mtimecmp != '0);

  // Combinational read of the current value
  always_comb begin
    valid_addr = 1'b1;
    csr_rdata  = '0;
    case (csr_addr)
      MVENDORID, MARCHID, MIMPID: csr_rdata = '0;
      MHARTID:   csr_rdata = HART_ID;
      MISA:      csr_rdata = MISA_VALUE;
      MSTATUS:   csr_rdata = mstatus_word;
      MIE:       csr_rdata = mie_word;
      MTVEC:     csr_rdata = mtvec;
      MSCRATCH:  csr_rdata = mscratch;
      MEPC:      csr_rdata = mepc;
      MCAUSE:    csr_rdata = mcause;
      MTVAL:     csr_rdata = mtval;
      MIP:       csr_rdata = mip_word;
      MTIMECMP:  csr_rdata = mtimecmp;
      MTIME:     csr_rdata = mtime[31:0];
      MTIMEH:    csr_rdata = mtime[63:32];
      MCYCLE:    csr_rdata = mcycle[31:0];
      MCYCLEH:   csr_rdata = mcycle[63:32];
      MINSTRET:  csr_rdata = minstret[31:0];
      MINSTRETH: csr_rdata = minstret[63:32];
      default:   valid_addr = 1'b0;
    endcase
  end

  assign invalid_csr = (csr_op != CSR_NONE) && !valid_addr;
  assign wr_en       = (csr_op != CSR_NONE) && valid_addr && !suppress_write;

  always_comb begin
    case (csr_op)
      CSR_SWAP: wr_data = csr_wdata;
      CSR_SET:  wr_data = csr_rdata | csr_wdata;
      CSR_CLR:  wr_data = csr_rdata & ~csr_wdata;
      default:  wr_data = csr_rdata;
    endcase
  end

  // mtime free-runs unless one of its halves is written
  always_comb begin
    mtime_nxt = mtime + 64'd1;
    if (wr_en && (csr_addr == MTIME)) begin
      mtime_nxt = {mtime[63:32], wr_data};
    end else if (wr_en && (csr_addr == MTIMEH)) begin
      mtime_nxt = {wr_data, mtime[31:0]};
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mie_bits     <= '0;
      mip_bits     <= '0;
      mtvec        <= '0;
      mscratch     <= '0;
      mepc         <= '0;
      mcause       <= '0;
      mtval        <= '0;
      mtimecmp     <= '0;
      mtime        <= '0;
      mcycle       <= '0;
      minstret     <= '0;
    end else begin
      mcycle   <= mcycle + 64'd1;
      minstret <= minstret + 64'(instr_retired);
      mtime    <= mtime_nxt;
      mip_bits <= {ext_int, timer_cond, soft_int};
      if (wr_en) begin
        case (csr_addr)
          MSTATUS: begin
            mstatus_mie  <= wr_data[MSTATUS_MIE_BIT];
            mstatus_mpie <= wr_data[MSTATUS_MPIE_BIT];
          end
          MIE: mie_bits <= {wr_data[MIP_MEIP_BIT], wr_data[MIP_MTIP_BIT], wr_data[MIP_MSIP_BIT]};
          // Direct mode only
          MTVEC:    mtvec    <= {wr_data[31:2], 2'b00};
          MSCRATCH: mscratch <= wr_data;
          MEPC:     mepc     <= wr_data;
          MCAUSE:   mcause   <= wr_data;
          MTVAL:    mtval    <= wr_data;
          MTIMECMP: mtimecmp <= wr_data;
          default: ;
        endcase
      end
      // Hardware updates come last so they take priority
      if (mstatus_rup) begin
        {mstatus_mpie, mstatus_mie} <= mstatus_next;
      end
      if (mepc_rup) begin
        mepc <= mepc_next;
      end
      if (mcause_rup) begin
        mcause <= mcause_next;
      end
      if (mtval_rup) begin
        mtval <= mtval_next;
      end
    end
  end

endmodule

// File: src/trap_arbiter.sv
// ---------------------------------------------------------------------------
// Selects the highest-priority exception, else the highest enabled interrupt,
// and encodes its mcause value and mtval value.
// ---------------------------------------------------------------------------
module trap_arbiter (
  input  logic                  fetch_misaligned,
  input  logic                  illegal_insn,
  input  logic                  ebreak,
  input  logic                  ecall,
  input  logic                  load_misaligned,
  input  logic                  store_misaligned,
  input  logic                  invalid_csr,
  input  priv_types_pkg::word_t fault_addr,
  input  logic                  mstatus_mie,
  input  logic [2:0]            mie_bits,
  input  logic [2:0]            mip_bits,
  output logic                  trap_taken,
  output priv_types_pkg::word_t trap_cause,
  output priv_types_pkg::word_t trap_value
);
  import priv_types_pkg::*;

  logic       exc_valid;
  logic       int_valid;
  logic [2:0] pending;
  exc_cause_e exc_code;
  int_cause_e int_code;

  // Fixed exception order, an illegal CSR access counts as illegal instruction
  always_comb begin
    exc_valid = 1'b1;
    if (fetch_misaligned) begin
      exc_code = EXC_FETCH_MISALIGNED;
    end else if (illegal_insn || invalid_csr) begin
      exc_code = EXC_ILLEGAL_INSN;
    end else if (ebreak) begin
      exc_code = EXC_BREAKPOINT;
    end else if (ecall) begin
      exc_code = EXC_ECALL_M;
    end else if (load_misaligned) begin
      exc_code = EXC_LOAD_MISALIGNED;
    end else if (store_misaligned) begin
      exc_code = EXC_STORE_MISALIGNED;
    end else begin
      exc_valid = 1'b0;
      exc_code  = EXC_FETCH_MISALIGNED;
    end
  end

  assign pending   = mie_bits & mip_bits;
  assign int_valid = mstatus_mie && (pending != 3'b000);

  // External first, then software, then timer
  always_comb begin
    if (pending[2]) begin
      int_code = INT_EXTERNAL;
    end else if (pending[0]) begin
      int_code = INT_SOFTWARE;
    end else begin
      int_code = INT_TIMER;
    end
  end

  assign trap_taken = exc_valid || int_valid;

  always_comb begin
    trap_cause = '0;
    trap_value = '0;
    if (exc_valid) begin
      trap_cause = {1'b0, exc_code};
      if (exc_code inside {EXC_FETCH_MISALIGNED, EXC_LOAD_MISALIGNED, EXC_STORE_MISALIGNED}) begin
        trap_value = fault_addr;
      end
    end else if (int_valid) begin
      trap_cause = {1'b1, int_code};
    end
  end

endmodule

// File: src/trap_control.sv
// ---------------------------------------------------------------------------
// Builds the trap and MRET hardware updates of mstatus, mepc, mcause, mtval
// and the redirect PC. A trap wins over an mret in the same cycle.
// ---------------------------------------------------------------------------
module trap_control (
  input  logic                  trap_taken,
  input  priv_types_pkg::word_t trap_cause,
  input  priv_types_pkg::word_t trap_value,
  input  logic                  mret,
  input  priv_types_pkg::word_t epc,
  input  priv_types_pkg::word_t mtvec,
  input  priv_types_pkg::word_t mepc,
  input  logic                  mstatus_mie,
  input  logic                  mstatus_mpie,
  output priv_types_pkg::word_t priv_pc,
  output logic                  insert_pc,
  output logic                  suppress_write,
  output logic                  mstatus_rup,
  output logic [1:0]            mstatus_next,
  output logic                  mepc_rup,
  output priv_types_pkg::word_t mepc_next,
  output logic                  mcause_rup,
  output priv_types_pkg::word_t mcause_next,
  output logic                  mtval_rup,
  output priv_types_pkg::word_t mtval_next
);

  logic do_mret;

  assign do_mret = mret && !trap_taken;

  // Redirect to the handler, or back to the saved PC
  assign priv_pc   = trap_taken ? mtvec : mepc;
  assign insert_pc = trap_taken || mret;

  // Pipeline CSR writes lose against a trap
  assign suppress_write = trap_taken;

  // {MPIE, MIE} push on trap, pop on MRET
  assign mstatus_rup = trap_taken || do_mret;
  always_comb begin
    if (trap_taken) begin
      mstatus_next = {mstatus_mie, 1'b0};
    end else begin
      mstatus_next = {1'b1, mstatus_mpie};
    end
  end

  assign mepc_rup    = trap_taken;
  assign mepc_next   = epc;
  assign mcause_rup  = trap_taken;
  assign mcause_next = trap_cause;
  assign mtval_rup   = trap_taken;
  assign mtval_next  = trap_value;

endmodule

// File: src/priv_unit.sv
// ---------------------------------------------------------------------------
// Machine-mode privilege unit top: CSR file, trap arbiter and trap controller.
// ---------------------------------------------------------------------------
module priv_unit #(
  parameter priv_types_pkg::word_t HART_ID = 32'd0
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  priv_types_pkg::csr_op_e csr_op,
  input  logic [11:0]             csr_addr,
  input  priv_types_pkg::word_t   csr_wdata,
  input  logic                    instr_retired,
  input  logic                    ext_int,
  input  logic                    soft_int,
  input  logic                    illegal_insn,
  input  logic                    ecall,
  input  logic                    ebreak,
  input  logic                    fetch_misaligned,
  input  logic                    load_misaligned,
  input  logic                    store_misaligned,
  input  priv_types_pkg::word_t   fault_addr,
  input  priv_types_pkg::word_t   epc,
  input  logic                    mret,
  output priv_types_pkg::word_t   csr_rdata,
  output logic                    invalid_csr,
  output logic                    trap_taken,
  output logic                    insert_pc,
  output priv_types_pkg::word_t   priv_pc
);
  import priv_types_pkg::*;

  // CSR state seen by the trap logic
  logic       mstatus_mie;
  logic       mstatus_mpie;
  logic [2:0] mie_bits;
  logic [2:0] mip_bits;
  word_t      mtvec;
  word_t      mepc;

  word_t      trap_cause;
  word_t      trap_value;

  // Hardware update path back into the CSR file
  logic       suppress_write;
  logic       mstatus_rup;
  logic [1:0] mstatus_next;
  logic       mepc_rup;
  word_t      mepc_next;
  logic       mcause_rup;
  word_t      mcause_next;
  logic       mtval_rup;
  word_t      mtval_next;

  csr_rfile #(
    .HART_ID(HART_ID)
  ) u_csr_rfile (.*);

  trap_arbiter u_trap_arbiter (.*);

  trap_control u_trap_control (.*);

endmodule

// File: test/priv_unit_tb.sv
// ---------------------------------------------------------------------------
// Self-checking testbench of the privilege unit: CSR ops, traps, MRET, counters.
// ---------------------------------------------------------------------------
module priv_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import priv_types_pkg::*;

  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 16;
  localparam word_t HART_ID      = 32'd5;
  localparam int    NUM_OPS      = 40;
  localparam int    NUM_EXC      = 10;
  localparam int    TIMER_CMP    = 20;
  localparam int    TIMER_WAIT   = 40;
  localparam int    NUM_RET      = 24;
  localparam int    MCYCLE_GAP   = 13;
  // Fixed steps (read-backs, setup writes, test gaps) come to about 60 cycles
  localparam int    TEST_CYCLES  = RESET_CYCLES + 2 * NUM_OPS + 7 * NUM_EXC + TIMER_WAIT
                                   + NUM_RET + MCYCLE_GAP + 60;
  localparam int    TIMEOUT_NS   = (TEST_CYCLES + 100) * CLK_PERIOD;

  // Counters and MIP first, they are read while reset is held
  localparam logic [11:0] CSR_LIST [20] = '{
    MIP, MTIME, MTIMEH, MCYCLE, MCYCLEH, MINSTRET, MINSTRETH,
    MVENDORID, MARCHID, MIMPID, MHARTID, MISA, MSTATUS, MIE,
    MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MTIMECMP
  };

  logic        CLK = 1'b0;
  logic        nRST;
  csr_op_e     csr_op;
  logic [11:0] csr_addr;
  word_t       csr_wdata;
  logic        instr_retired;
  logic        ext_int;
  logic        soft_int;
  logic        illegal_insn;
  logic        ecall;
  logic        ebreak;
  logic        fetch_misaligned;
  logic        load_misaligned;
  logic        store_misaligned;
  word_t       fault_addr;
  word_t       epc;
  logic        mret;
  word_t       csr_rdata;
  logic        invalid_csr;
  logic        trap_taken;
  logic        insert_pc;
  word_t       priv_pc;

  // Expected responses of the current cycle
  logic  exp_rd_en;
  logic  exp_ctl_en;
  logic  exp_trap;
  logic  exp_insert;
  logic  exp_inv;
  word_t exp_rd;
  word_t exp_pc;

  // Model copy of the writable machine state
  word_t m_mscratch;
  word_t m_mtvec;
  word_t m_mie_reg;
  word_t m_mepc;
  word_t m_mcause;
  word_t m_mtval;
  word_t m_mtimecmp;
  logic  m_st_mie;
  logic  m_st_mpie;

  string cur_test;
  int    err_count;
  int    checks_run;
  int    tests_run;
  int    tests_failed;
  int    test_errs;

  priv_unit #(.HART_ID(HART_ID)) UUT (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic check(input string name, input word_t exp, input word_t act);
    checks_run++;
    if (exp !== act) begin
      err_count++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic word_t csr_model(input csr_op_e op, input logic [11:0] addr,
                                      input word_t old, input word_t wdata);
    word_t v;
    case (op)
      CSR_SWAP: v = wdata;
      CSR_SET:  v = old | wdata;
      CSR_CLR:  v = old & ~wdata;
      default:  v = old;
    endcase
    case (addr)
      MTVEC:   v[1:0] = 2'b00;
      MIE:     v = v & 32'h0000_0888;
      MSTATUS: v = v & 32'h0000_0088;
      MISA, MHARTID, MVENDORID, MARCHID, MIMPID: v = old;
      default: ;
    endcase
    return v;
  endfunction

  function automatic word_t model_read(input logic [11:0] addr);
    case (addr)
      MISA:     return MISA_VALUE;
      MHARTID:  return HART_ID;
      MSTATUS:  return {24'b0, m_st_mpie, 3'b0, m_st_mie, 3'b0};
      MIE:      return m_mie_reg;
      MTVEC:    return m_mtvec;
      MSCRATCH: return m_mscratch;
      MEPC:     return m_mepc;
      MCAUSE:   return m_mcause;
      MTVAL:    return m_mtval;
      MTIMECMP: return m_mtimecmp;
      default:  return '0;
    endcase
  endfunction

  function automatic void model_write(input logic [11:0] addr, input word_t v);
    case (addr)
      MSTATUS: begin
        m_st_mie  = v[3];
        m_st_mpie = v[7];
      end
      MIE:      m_mie_reg  = v;
      MTVEC:    m_mtvec    = v;
      MSCRATCH: m_mscratch = v;
      MTIMECMP: m_mtimecmp = v;
      default: ;
    endcase
  endfunction

  // exc is {fetch, illegal, ebreak, ecall, load, store}, irq is {ext, timer, soft}
  function automatic logic trap_model(input logic [5:0] exc, input logic [2:0] irq,
                                      input word_t addr, input word_t pc);
    word_t      cause;
    word_t      tval;
    logic [2:0] pend;
    pend = irq & {m_mie_reg[11], m_mie_reg[7], m_mie_reg[3]};
    tval = '0;
    if (exc[5]) begin
      cause = 32'd0;
      tval  = addr;
    end else if (exc[4]) begin
      cause = 32'd2;
    end else if (exc[3]) begin
      cause = 32'd3;
    end else if (exc[2]) begin
      cause = 32'd11;
    end else if (exc[1]) begin
      cause = 32'd4;
      tval  = addr;
    end else if (exc[0]) begin
      cause = 32'd6;
      tval  = addr;
    end else if (m_st_mie && (pend != 3'b000)) begin
      if (pend[2]) begin
        cause = 32'h8000_000B;
      end else if (pend[0]) begin
        cause = 32'h8000_0003;
      end else begin
        cause = 32'h8000_0007;
      end
    end else begin
      return 1'b0;
    end
    m_mepc    = pc;
    m_mcause  = cause;
    m_mtval   = tval;
    m_st_mpie = m_st_mie;
    m_st_mie  = 1'b0;
    return 1'b1;
  endfunction

  // Pipeline inputs back to idle, interrupt levels and epc are left alone
  task automatic clear_inputs();
    csr_op           = CSR_NONE;
    csr_addr         = MSCRATCH;
    csr_wdata        = '0;
    instr_retired    = 1'b0;
    mret             = 1'b0;
    {fetch_misaligned, illegal_insn, ebreak, ecall, load_misaligned, store_misaligned} = '0;
    exp_rd_en  = 1'b0;
    exp_ctl_en = 1'b1;
    exp_trap   = 1'b0;
    exp_insert = 1'b0;
    exp_inv    = 1'b0;
    exp_pc     = '0;
  endtask

  task automatic csr_cycle(input csr_op_e op, input logic [11:0] addr, input word_t wdata,
                           input logic rd_chk, input word_t rd_val);
    @(negedge CLK);
    clear_inputs();
    csr_op    = op;
    csr_addr  = addr;
    csr_wdata = wdata;
    exp_rd_en = rd_chk;
    exp_rd    = rd_val;
  endtask

  task automatic read_check(input logic [11:0] addr);
    csr_cycle(CSR_NONE, addr, '0, 1'b1, model_read(addr));
  endtask

  // Read data shows the old value, the model moves on to the new one
  task automatic csr_write(input csr_op_e op, input logic [11:0] addr, input word_t wdata);
    word_t old;
    old = model_read(addr);
    csr_cycle(op, addr, wdata, 1'b1, old);
    model_write(addr, csr_model(op, addr, old, wdata));
  endtask

  task automatic trap_cycle(input logic [5:0] exc, input logic [2:0] irq, input word_t addr,
                            input word_t pc, input logic pipe_write);
    @(negedge CLK);
    clear_inputs();
    {fetch_misaligned, illegal_insn, ebreak, ecall, load_misaligned, store_misaligned} = exc;
    fault_addr = addr;
    epc        = pc;
    exp_pc     = m_mtvec;
    exp_trap   = trap_model(exc, irq, addr, pc);
    exp_insert = exp_trap;
    // Competing write that the trap has to block
    if (pipe_write) begin
      csr_op    = CSR_SWAP;
      csr_addr  = MSCRATCH;
      csr_wdata = ~m_mscratch;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = err_count;
    tests_run++;
  endtask

  task automatic end_test();
    @(negedge CLK);
    clear_inputs();
    if (err_count == test_errs) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, err_count - test_errs);
    end
  endtask

  // Outputs are compared at the rising edge, half a cycle after the drive
  always @(posedge CLK) begin
    if (exp_rd_en) begin
      check({cur_test, " csr_rdata"}, exp_rd, csr_rdata);
    end
    if (exp_ctl_en) begin
      check({cur_test, " trap_taken"}, 32'(exp_trap), 32'(trap_taken));
      check({cur_test, " insert_pc"}, 32'(exp_insert), 32'(insert_pc));
      check({cur_test, " invalid_csr"}, 32'(exp_inv), 32'(invalid_csr));
      if (exp_insert) begin
        check({cur_test, " priv_pc"}, exp_pc, priv_pc);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int          i;
    int          n;
    int          pulses;
    logic        seen;
    logic [5:0]  exc;
    logic [11:0] addr;
    csr_op_e     op;
    word_t       pc;
    word_t       c0;
    word_t       c1;
    void'($urandom(71535));
    err_count    = 0;
    checks_run   = 0;
    tests_run    = 0;
    tests_failed = 0;
    {m_mscratch, m_mtvec, m_mie_reg, m_mepc, m_mcause, m_mtval, m_mtimecmp} = '0;
    m_st_mie   = 1'b0;
    m_st_mpie  = 1'b0;
    nRST       = 1'b0;
    ext_int    = 1'b0;
    soft_int   = 1'b0;
    fault_addr = '0;
    epc        = '0;
    exp_rd     = '0;
    cur_test   = "reset";
    clear_inputs();

    begin_test("reset");
    for (i = 0; i < RESET_CYCLES; i++) begin
      @(negedge CLK);
      clear_inputs();
      if (i < 7) begin
        csr_addr  = CSR_LIST[i];
        exp_rd_en = 1'b1;
        exp_rd    = model_read(CSR_LIST[i]);
      end
    end
    nRST = 1'b1;
    for (i = 7; i < 20; i++) begin
      read_check(CSR_LIST[i]);
    end
    end_test();

    begin_test("csr_ops");
    for (i = 0; i < NUM_OPS; i++) begin
      case ($urandom_range(0, 2))
        0:       addr = MSCRATCH;
        1:       addr = MTVEC;
        default: addr = MIE;
      endcase
      case ($urandom_range(0, 2))
        0:       op = CSR_SWAP;
        1:       op = CSR_SET;
        default: op = CSR_CLR;
      endcase
      csr_write(op, addr, $urandom());
      read_check(addr);
    end
    csr_write(CSR_SWAP, MISA, $urandom());
    read_check(MISA);
    end_test();

    begin_test("invalid_csr");
    csr_write(CSR_SWAP, MSCRATCH, 32'h1234_5678);
    csr_cycle(CSR_SWAP, 12'h7FF, 32'hFFFF_FFFF, 1'b0, '0);
    epc        = 32'h0000_2004;
    exp_pc     = m_mtvec;
    exp_trap   = trap_model(6'b010000, 3'b000, '0, epc);
    exp_insert = exp_trap;
    exp_inv    = 1'b1;
    read_check(MSCRATCH);
    read_check(MCAUSE);
    read_check(MEPC);
    read_check(MTVAL);
    end_test();

    begin_test("exceptions");
    csr_write(CSR_SWAP, MTVEC, 32'h0000_1000);
    for (i = 0; i < NUM_EXC; i++) begin
      // Single strobes first, then random combinations for priority
      exc = (i < 6) ? 6'(1 << i) : 6'($urandom_range(1, 63));
      csr_write(CSR_SWAP, MSTATUS, 32'h0000_0008);
      trap_cycle(exc, 3'b000, $urandom(), $urandom(), 1'b1);
      read_check(MEPC);
      read_check(MCAUSE);
      read_check(MTVAL);
      read_check(MSTATUS);
    end
    read_check(MSCRATCH);
    end_test();

    begin_test("interrupts");
    csr_write(CSR_SWAP, MIE, 32'hFFFF_FFFF);
    csr_write(CSR_SWAP, MSTATUS, 32'h0000_0008);
    pc = 32'h0000_3000;
    trap_cycle(6'b0, 3'b000, '0, pc, 1'b0);
    ext_int  = 1'b1;
    soft_int = 1'b1;
    // mip sees both one cycle later, MIE is clear after the trap
    trap_cycle(6'b0, 3'b101, '0, pc, 1'b0);
    trap_cycle(6'b0, 3'b101, '0, pc, 1'b0);
    ext_int  = 1'b0;
    soft_int = 1'b0;
    read_check(MCAUSE);
    read_check(MEPC);
    csr_write(CSR_SWAP, MSTATUS, 32'h0000_0008);
    csr_cycle(CSR_SWAP, MTIME, '0, 1'b0, '0);
    csr_write(CSR_SWAP, MTIMECMP, TIMER_CMP);
    epc  = 32'h0000_3040;
    seen = 1'b0;
    for (n = 0; (n < TIMER_WAIT) && !seen; n++) begin
      @(negedge CLK);
      clear_inputs();
      exp_ctl_en = 1'b0;
      @(posedge CLK);
      seen = trap_taken;
    end
    if (seen) begin
      check("interrupts timer priv_pc", m_mtvec, priv_pc);
      void'(trap_model(6'b0, 3'b010, '0, epc));
    end else begin
      err_count++;
      $display("timer interrupt did not arrive within %0d cycles", TIMER_WAIT);
    end
    read_check(MCAUSE);
    // Sources pending but MIE is clear
    for (i = 0; i < 3; i++) begin
      trap_cycle(6'b0, 3'b111, '0, epc, 1'b0);
      ext_int = 1'b1;
    end
    ext_int = 1'b0;
    csr_write(CSR_SWAP, MTIMECMP, '0);
    end_test();

    begin_test("mret_counters");
    read_check(MEPC);
    read_check(MSTATUS);
    @(negedge CLK);
    clear_inputs();
    mret       = 1'b1;
    exp_insert = 1'b1;
    exp_pc     = m_mepc;
    m_st_mie   = m_st_mpie;
    m_st_mpie  = 1'b1;
    read_check(MSTATUS);
    pulses = 0;
    for (i = 0; i < NUM_RET; i++) begin
      @(negedge CLK);
      clear_inputs();
      instr_retired = 1'($urandom_range(0, 1));
      pulses += int'(instr_retired);
    end
    csr_cycle(CSR_NONE, MINSTRET, '0, 1'b1, word_t'(pulses));
    @(negedge CLK);
    clear_inputs();
    csr_addr = MCYCLE;
    @(posedge CLK);
    c0 = csr_rdata;
    repeat (MCYCLE_GAP) @(posedge CLK);
    c1 = csr_rdata;
    check("mret_counters mcycle delta", MCYCLE_GAP, c1 - c0);
    end_test();

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks_run, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
src/priv_types_pkg.sv
src/csr_rfile.sv
src/trap_arbiter.sv
src/trap_control.sv
src/priv_unit.sv
test/priv_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --timescale 1ns/100ps
TOP       ?= priv_unit_tb
RTL_TOP   ?= priv_unit
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
